/* project.f */
+incdir+.
rv_isa_pkg.sv
rv_decode_pkg.sv
rv_opcode_map.sv
rv_ctrl_decode.sv
rv_imm_gen.sv
rv_decode_reg.sv
rv_decoder_top.sv
tb_rv_decoder.sv

/* rv_ctrl_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl_decode
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  rv_inst_u   inst_i,
    output inst_type_e inst_type_o,
    output alu_e       alu_type_o,
    output ope_sel_e   ope_sel_o,
    output data_size_e data_size_o
);

    localparam bit         RV64 = (XLEN == 64);
    localparam logic [6:0] ANY7 = 7'b???????;
    localparam logic [2:0] ANY3 = 3'b???;

    logic [16:0] key;
    logic [2:0]  funct3;
    logic        alt;
    logic        imm_alt;
    logic        shamt_hi;

    assign funct3   = inst_i.r.funct3;
    assign key      = {inst_i.r.funct7, funct3, inst_i.r.opcode};
    assign alt      = inst_i.r.funct7[5];
    // In immediate forms bit 30 means SRA only for the right shift
    assign imm_alt  = alt && (funct3 == F3_SRL);
    // Shift amount above 31, legal on RV64 only
    assign shamt_hi = inst_i.r.funct7[0] && (funct3 == F3_SLL || funct3 == F3_SRL);

    function automatic alu_e arith_alu(input logic [2:0] f3, input logic alt_op);
        case (f3)
            F3_ADD:  return alt_op ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_LT;
            F3_SLTU: return ALU_LTU;
            F3_XOR:  return ALU_XOR;
            F3_SRL:  return alt_op ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic alu_e branch_alu(input logic [2:0] f3);
        case (f3)
            F3_BEQ:  return ALU_EQ;
            F3_BNE:  return ALU_NE;
            F3_BLT:  return ALU_LT;
            F3_BGE:  return ALU_GE;
            F3_BLTU: return ALU_LTU;
            F3_BGEU: return ALU_GEU;
            default: return ALU_NOP;
        endcase
    endfunction

    function automatic data_size_e load_size(input logic [2:0] f3);
        case (f3)
            F3_LB:   return BYTE_S;
            F3_LH:   return HALF_S;
            F3_LW:   return WORD_S;
            F3_LD:   return DWORD;
            F3_LBU:  return BYTE_U;
            F3_LHU:  return HALF_U;
            F3_LWU:  return WORD_U;
            default: return DATA_NONE;
        endcase
    endfunction

    //////////////////////////////
    // Instruction table
    //////////////////////////////
    always_comb begin
        inst_type_o = I_TYPE;
        alu_type_o  = ALU_NOP;
        ope_sel_o   = OPE_NOP;
        data_size_o = DATA_NONE;
        unique casez (key)
            {ANY7, ANY3, OPC_LUI}: begin
                inst_type_o = U_TYPE;
                alu_type_o  = ALU_LUI;
                ope_sel_o   = OPE_RS1_RS2_IMM;
            end
            {ANY7, ANY3, OPC_AUIPC}: begin
                inst_type_o = U_TYPE;
                alu_type_o  = ALU_AUIPC;
                ope_sel_o   = OPE_RS1_RS2_IMM;
            end
            {ANY7, ANY3, OPC_JAL}: begin
                inst_type_o = J_TYPE;
                alu_type_o  = ALU_JAL;
                ope_sel_o   = OPE_RS1_RS2_IMM;
            end
            {ANY7, F3_JALR, OPC_JALR}: begin
                alu_type_o = ALU_JALR;
                ope_sel_o  = OPE_RS1_IMM;
            end
            {ANY7, 3'b00?, OPC_BRANCH}, {ANY7, 3'b1??, OPC_BRANCH}: begin
                inst_type_o = B_TYPE;
                alu_type_o  = branch_alu(funct3);
                ope_sel_o   = OPE_RS1_RS2_IMM;
            end
            {ANY7, 3'b0??, OPC_LOAD}, {ANY7, 3'b10?, OPC_LOAD}, {ANY7, F3_LWU, OPC_LOAD}: begin
                if (RV64 || !(funct3 inside {F3_LD, F3_LWU})) begin
                    alu_type_o  = ALU_ADD;
                    ope_sel_o   = OPE_RS1_IMM;
                    data_size_o = load_size(funct3);
                end
            end
            {ANY7, 3'b0??, OPC_STORE}: begin
                if (RV64 || funct3 != F3_SD) begin
                    inst_type_o = S_TYPE;
                    alu_type_o  = ALU_ADD;
                    ope_sel_o   = OPE_RS1_IMM;
                    // SB, SH and SW take the unsigned sizes
                    data_size_o = (funct3 == F3_SD) ? DWORD : load_size({1'b1, funct3[1:0]});
                end
            end
            {ANY7, F3_ADD, OPC_OP_IMM}, {ANY7, 3'b01?, OPC_OP_IMM},
            {ANY7, 3'b1?0, OPC_OP_IMM}, {ANY7, F3_AND, OPC_OP_IMM},
            {7'b000000?, F3_SLL, OPC_OP_IMM}, {7'b0?0000?, F3_SRL, OPC_OP_IMM}: begin
                if (RV64 || !shamt_hi) begin
                    alu_type_o = arith_alu(funct3, imm_alt);
                    ope_sel_o  = OPE_RS1_IMM;
                end
            end
            {F7_BASE, ANY3, OPC_OP}, {F7_ALT, F3_ADD, OPC_OP}, {F7_ALT, F3_SRL, OPC_OP}: begin
                inst_type_o = R_TYPE;
                alu_type_o  = arith_alu(funct3, alt);
                ope_sel_o   = OPE_RS1_RS2;
            end
            // RV64 W forms
            {ANY7, F3_ADD, OPC_OP_IMM_32}, {F7_BASE, F3_SLL, OPC_OP_IMM_32},
            {7'b0?00000, F3_SRL, OPC_OP_IMM_32}: begin
                if (RV64) begin
                    alu_type_o = arith_alu(funct3, imm_alt);
                    ope_sel_o  = OPE_RS1_IMM;
                end
            end
            {7'b0?00000, F3_ADD, OPC_OP_32}, {F7_BASE, F3_SLL, OPC_OP_32},
            {7'b0?00000, F3_SRL, OPC_OP_32}: begin
                if (RV64) begin
                    inst_type_o = R_TYPE;
                    alu_type_o  = arith_alu(funct3, alt);
                    ope_sel_o   = OPE_RS1_RS2;
                end
            end
            default: begin
                // Anything else keeps the NOP row
            end
        endcase
    end

    // Operand selection and ALU op agree on which rows are real instructions
    a_nop_pairing: assert final ((ope_sel_o == OPE_NOP) == (alu_type_o == ALU_NOP));

endmodule

`default_nettype wire

/* rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

    // Major opcode class
    typedef enum logic [4:0] {
        LOAD, LOAD_FP, MISC_MEM, OP_IMM, AUIPC_OP, OP_IMM_32,
        STORE, STORE_FP, AMO, OP, LUI_OP, OP_32,
        MADD, MSUB, NMSUB, NMADD, OP_FP, OP_V,
        BRANCH, JALR_OP, JAL_OP, SYSTEM, OP_VE,
        RESERVED
    } opcode_e;

    // Immediate format
    typedef enum logic [2:0] {
        R_TYPE,
        R4_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } inst_type_e;

    // ALU operation, comparisons double as branch conditions
    typedef enum logic [4:0] {
        ALU_NOP,
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_XOR, ALU_OR, ALU_AND,
        ALU_LT, ALU_LTU, ALU_EQ, ALU_NE, ALU_GE, ALU_GEU,
        ALU_LUI, ALU_AUIPC, ALU_JAL, ALU_JALR
    } alu_e;

    // Operand selection
    typedef enum logic [1:0] {
        OPE_NOP,
        OPE_RS1_RS2,
        OPE_RS1_IMM,
        OPE_RS1_RS2_IMM
    } ope_sel_e;

    // Memory access size, DATA_NONE for everything but loads and stores
    typedef enum logic [2:0] {
        DATA_NONE,
        BYTE_S,
        HALF_S,
        WORD_S,
        BYTE_U,
        HALF_U,
        WORD_U,
        DWORD
    } data_size_e;

endpackage

`default_nettype wire

/* rv_decode_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode_reg
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  inst_valid_i,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [REG_ADDR_W-1:0] rs3_addr_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  opcode_e               opcode_i,
    input  alu_e                  alu_type_i,
    input  ope_sel_e              ope_sel_i,
    input  data_size_e            data_size_i,
    input  logic [XLEN-1:0]       imm_i,
    output logic                  dec_valid_o,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    output logic [REG_ADDR_W-1:0] rs3_addr_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output opcode_e               opcode_o,
    output alu_e                  alu_type_o,
    output ope_sel_e              ope_sel_o,
    output data_size_e            data_size_o,
    output logic [XLEN-1:0]       imm_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= inst_valid_i;
        end
    end

    // Outputs hold between strobes
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rs1_addr_o  <= '0;
            rs2_addr_o  <= '0;
            rs3_addr_o  <= '0;
            rd_addr_o   <= '0;
            opcode_o    <= opcode_e'(0);
            alu_type_o  <= ALU_NOP;
            ope_sel_o   <= OPE_NOP;
            data_size_o <= DATA_NONE;
            imm_o       <= '0;
        end else if (inst_valid_i) begin
            rs1_addr_o  <= rs1_addr_i;
            rs2_addr_o  <= rs2_addr_i;
            rs3_addr_o  <= rs3_addr_i;
            // Stores and branches write no register
            rd_addr_o   <= (opcode_i inside {STORE, STORE_FP, BRANCH}) ? '0 : rd_addr_i;
            opcode_o    <= opcode_i;
            alu_type_o  <= alu_type_i;
            ope_sel_o   <= ope_sel_i;
            data_size_o <= data_size_i;
            imm_o       <= imm_i;
        end
    end

    a_valid_after_strobe: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        dec_valid_o |-> $past(inst_valid_i)
    );

endmodule

`default_nettype wire

/* rv_decoder_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder_top
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  inst_valid_i,
    input  rv_inst_u              inst_i,
    output logic                  dec_valid_o,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    output logic [REG_ADDR_W-1:0] rs3_addr_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic [XLEN-1:0]       imm_o,
    output opcode_e               opcode_o,
    output alu_e                  alu_type_o,
    output ope_sel_e              ope_sel_o,
    output data_size_e            data_size_o
);

    opcode_e         opcode;
    inst_type_e      inst_type;
    alu_e            alu_type;
    ope_sel_e        ope_sel;
    data_size_e      data_size;
    logic [XLEN-1:0] imm;

    rv_opcode_map rv_opcode_map_inst (
        .opcode_i (inst_i.r.opcode),
        .opcode_o (opcode)
    );

    rv_ctrl_decode #(
        .XLEN (XLEN)
    ) rv_ctrl_decode_inst (
        .inst_i      (inst_i),
        .inst_type_o (inst_type),
        .alu_type_o  (alu_type),
        .ope_sel_o   (ope_sel),
        .data_size_o (data_size)
    );

    rv_imm_gen #(
        .XLEN (XLEN)
    ) rv_imm_gen_inst (
        .inst_i      (inst_i),
        .inst_type_i (inst_type),
        .imm_o       (imm)
    );

    // rs3 sits in bits 31:27, the top of funct7
    rv_decode_reg #(
        .XLEN (XLEN)
    ) rv_decode_reg_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .rs1_addr_i   (inst_i.r.rs1),
        .rs2_addr_i   (inst_i.r.rs2),
        .rs3_addr_i   (inst_i.r.funct7[6:2]),
        .rd_addr_i    (inst_i.r.rd),
        .opcode_i     (opcode),
        .alu_type_i   (alu_type),
        .ope_sel_i    (ope_sel),
        .data_size_i  (data_size),
        .imm_i        (imm),
        .dec_valid_o  (dec_valid_o),
        .rs1_addr_o   (rs1_addr_o),
        .rs2_addr_o   (rs2_addr_o),
        .rs3_addr_o   (rs3_addr_o),
        .rd_addr_o    (rd_addr_o),
        .opcode_o     (opcode_o),
        .alu_type_o   (alu_type_o),
        .ope_sel_o    (ope_sel_o),
        .data_size_o  (data_size_o),
        .imm_o        (imm_o)
    );

endmodule

`default_nettype wire

/* rv_imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  rv_inst_u        inst_i,
    input  inst_type_e      inst_type_i,
    output logic [XLEN-1:0] imm_o
);

    logic            sign;
    logic [ILEN-1:0] imm32;

    // Bit 31 is the sign in every format
    assign sign = inst_i.i.imm12[11];

    always_comb begin
        unique case (inst_type_i)
            I_TYPE: begin
                imm32 = {{20{sign}}, inst_i.i.imm12};
            end
            S_TYPE: begin
                imm32 = {{20{sign}}, inst_i.r.funct7, inst_i.r.rd};
            end
            B_TYPE: begin
                imm32 = {{19{sign}}, sign, inst_i.r.rd[0], inst_i.r.funct7[5:0],
                         inst_i.r.rd[4:1], 1'b0};
            end
            U_TYPE: begin
                imm32 = {inst_i.i.imm12, inst_i.i.rs1, inst_i.i.funct3, 12'd0};
            end
            J_TYPE: begin
                // imm[19:12] sits in the rs1 and funct3 fields
                imm32 = {{11{sign}}, sign, inst_i.i.rs1, inst_i.i.funct3,
                         inst_i.i.imm12[0], inst_i.i.imm12[10:1], 1'b0};
            end
            default: begin
                // R and R4 carry no immediate
                imm32 = '0;
            end
        endcase
    end

    assign imm_o = XLEN'($signed(imm32));

endmodule

`default_nettype wire

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    //////////////////////////////
    // Word and field widths
    //////////////////////////////
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;

    //////////////////////////////
    // Major opcodes, bits 6:0
    //////////////////////////////
    localparam logic [OPCODE_W-1:0] OPC_LOAD      = 7'b00_000_11;
    localparam logic [OPCODE_W-1:0] OPC_LOAD_FP   = 7'b00_001_11;
    localparam logic [OPCODE_W-1:0] OPC_MISC_MEM  = 7'b00_011_11;
    localparam logic [OPCODE_W-1:0] OPC_OP_IMM    = 7'b00_100_11;
    localparam logic [OPCODE_W-1:0] OPC_AUIPC     = 7'b00_101_11;
    localparam logic [OPCODE_W-1:0] OPC_OP_IMM_32 = 7'b00_110_11;
    localparam logic [OPCODE_W-1:0] OPC_STORE     = 7'b01_000_11;
    localparam logic [OPCODE_W-1:0] OPC_STORE_FP  = 7'b01_001_11;
    localparam logic [OPCODE_W-1:0] OPC_AMO       = 7'b01_011_11;
    localparam logic [OPCODE_W-1:0] OPC_OP        = 7'b01_100_11;
    localparam logic [OPCODE_W-1:0] OPC_LUI       = 7'b01_101_11;
    localparam logic [OPCODE_W-1:0] OPC_OP_32     = 7'b01_110_11;
    localparam logic [OPCODE_W-1:0] OPC_MADD      = 7'b10_000_11;
    localparam logic [OPCODE_W-1:0] OPC_MSUB      = 7'b10_001_11;
    localparam logic [OPCODE_W-1:0] OPC_NMSUB     = 7'b10_010_11;
    localparam logic [OPCODE_W-1:0] OPC_NMADD     = 7'b10_011_11;
    localparam logic [OPCODE_W-1:0] OPC_OP_FP     = 7'b10_100_11;
    localparam logic [OPCODE_W-1:0] OPC_OP_V      = 7'b10_101_11;
    localparam logic [OPCODE_W-1:0] OPC_BRANCH    = 7'b11_000_11;
    localparam logic [OPCODE_W-1:0] OPC_JALR      = 7'b11_001_11;
    localparam logic [OPCODE_W-1:0] OPC_JAL       = 7'b11_011_11;
    localparam logic [OPCODE_W-1:0] OPC_SYSTEM    = 7'b11_100_11;
    localparam logic [OPCODE_W-1:0] OPC_OP_VE     = 7'b11_101_11;

    // Integer ALU funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Load and store widths
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;
    localparam logic [2:0] F3_SD  = 3'b011;

    // funct7, the alternate form selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b000_0000;
    localparam logic [6:0] F7_ALT  = 7'b010_0000;

    // Register view and immediate view of one instruction word
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [OPCODE_W-1:0]   opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [OPCODE_W-1:0]   opcode;
        } i;
    } rv_inst_u;

endpackage

`default_nettype wire

/* rv_opcode_map.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_opcode_map
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
(
    input  logic [OPCODE_W-1:0] opcode_i,
    output opcode_e             opcode_o
);

    // Custom slots, the reserved slot and non-32-bit encodings fall to RESERVED
    always_comb begin
        unique case (opcode_i)
            OPC_LOAD:      opcode_o = LOAD;
            OPC_LOAD_FP:   opcode_o = LOAD_FP;
            OPC_MISC_MEM:  opcode_o = MISC_MEM;
            OPC_OP_IMM:    opcode_o = OP_IMM;
            OPC_AUIPC:     opcode_o = AUIPC_OP;
            OPC_OP_IMM_32: opcode_o = OP_IMM_32;
            OPC_STORE:     opcode_o = STORE;
            OPC_STORE_FP:  opcode_o = STORE_FP;
            OPC_AMO:       opcode_o = AMO;
            OPC_OP:        opcode_o = OP;
            OPC_LUI:       opcode_o = LUI_OP;
            OPC_OP_32:     opcode_o = OP_32;
            OPC_MADD:      opcode_o = MADD;
            OPC_MSUB:      opcode_o = MSUB;
            OPC_NMSUB:     opcode_o = NMSUB;
            OPC_NMADD:     opcode_o = NMADD;
            OPC_OP_FP:     opcode_o = OP_FP;
            OPC_OP_V:      opcode_o = OP_V;
            OPC_BRANCH:    opcode_o = BRANCH;
            OPC_JALR:      opcode_o = JALR_OP;
            OPC_JAL:       opcode_o = JAL_OP;
            OPC_SYSTEM:    opcode_o = SYSTEM;
            OPC_OP_VE:     opcode_o = OP_VE;
            default:       opcode_o = RESERVED;
        endcase
    end

endmodule

`default_nettype wire

/* tb_rv_decoder_model.svh */
`ifndef TB_RV_DECODER_MODEL_SVH
`define TB_RV_DECODER_MODEL_SVH

//////////////////////////////
// Major opcode map
//////////////////////////////
function automatic opcode_e opcode_class(input logic [6:0] opc);
    case (opc)
        OPC_LOAD:      return LOAD;
        OPC_LOAD_FP:   return LOAD_FP;
        OPC_MISC_MEM:  return MISC_MEM;
        OPC_OP_IMM:    return OP_IMM;
        OPC_AUIPC:     return AUIPC_OP;
        OPC_OP_IMM_32: return OP_IMM_32;
        OPC_STORE:     return STORE;
        OPC_STORE_FP:  return STORE_FP;
        OPC_AMO:       return AMO;
        OPC_OP:        return OP;
        OPC_LUI:       return LUI_OP;
        OPC_OP_32:     return OP_32;
        OPC_MADD:      return MADD;
        OPC_MSUB:      return MSUB;
        OPC_NMSUB:     return NMSUB;
        OPC_NMADD:     return NMADD;
        OPC_OP_FP:     return OP_FP;
        OPC_OP_V:      return OP_V;
        OPC_BRANCH:    return BRANCH;
        OPC_JALR:      return JALR_OP;
        OPC_JAL:       return JAL_OP;
        OPC_SYSTEM:    return SYSTEM;
        OPC_OP_VE:     return OP_VE;
        default:       return RESERVED;
    endcase
endfunction

// Integer operation picked by funct3, alt selects SUB or SRA
function automatic alu_e int_op(input logic [2:0] f3, input logic alt);
    case (f3)
        3'b000:  return alt ? ALU_SUB : ALU_ADD;
        3'b001:  return ALU_SLL;
        3'b010:  return ALU_LT;
        3'b011:  return ALU_LTU;
        3'b100:  return ALU_XOR;
        3'b101:  return alt ? ALU_SRA : ALU_SRL;
        3'b110:  return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

//////////////////////////////
// Expected control fields for any word, XLEN of 64
//////////////////////////////
function automatic void predict_ctrl(input logic [31:0] w, output inst_type_e fmt,
                                     output alu_e alu, output ope_sel_e ope,
                                     output data_size_e size);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       legal;
    f3    = w[14:12];
    f7    = w[31:25];
    fmt   = I_TYPE;
    alu   = ALU_NOP;
    ope   = OPE_NOP;
    size  = DATA_NONE;
    legal = 1'b0;
    case (w[6:0])
        OPC_LUI, OPC_AUIPC: begin
            fmt = U_TYPE;
            alu = (w[6:0] == OPC_LUI) ? ALU_LUI : ALU_AUIPC;
            ope = OPE_RS1_RS2_IMM;
        end
        OPC_JAL: begin
            fmt = J_TYPE;
            alu = ALU_JAL;
            ope = OPE_RS1_RS2_IMM;
        end
        OPC_JALR: begin
            if (f3 == 3'b000) begin
                alu = ALU_JALR;
                ope = OPE_RS1_IMM;
            end
        end
        OPC_BRANCH: begin
            legal = 1'b1;
            case (f3)
                3'b000:  alu = ALU_EQ;
                3'b001:  alu = ALU_NE;
                3'b100:  alu = ALU_LT;
                3'b101:  alu = ALU_GE;
                3'b110:  alu = ALU_LTU;
                3'b111:  alu = ALU_GEU;
                default: legal = 1'b0;
            endcase
            if (legal) begin
                fmt = B_TYPE;
                ope = OPE_RS1_RS2_IMM;
            end
        end
        OPC_LOAD: begin
            if (f3 != 3'b111) begin
                alu = ALU_ADD;
                ope = OPE_RS1_IMM;
                case (f3)
                    3'b000:  size = BYTE_S;
                    3'b001:  size = HALF_S;
                    3'b010:  size = WORD_S;
                    3'b011:  size = DWORD;
                    3'b100:  size = BYTE_U;
                    3'b101:  size = HALF_U;
                    default: size = WORD_U;
                endcase
            end
        end
        OPC_STORE: begin
            if (!f3[2]) begin
                fmt = S_TYPE;
                alu = ALU_ADD;
                ope = OPE_RS1_IMM;
                // Store sizes are reported unsigned
                case (f3[1:0])
                    2'b00:   size = BYTE_U;
                    2'b01:   size = HALF_U;
                    2'b10:   size = WORD_U;
                    default: size = DWORD;
                endcase
            end
        end
        OPC_OP_IMM: begin
            if (f3 == 3'b001) begin
                legal = (f7[6:1] == 6'd0);
            end else if (f3 == 3'b101) begin
                legal = ({f7[6], f7[4:1]} == 5'd0);
            end else begin
                legal = 1'b1;
            end
            if (legal) begin
                alu = int_op(f3, (f3 == 3'b101) && f7[5]);
                ope = OPE_RS1_IMM;
            end
        end
        OPC_OP: begin
            if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
                fmt = R_TYPE;
                alu = int_op(f3, f7[5]);
                ope = OPE_RS1_RS2;
            end
        end
        OPC_OP_IMM_32: begin
            legal = (f3 == 3'b000) || (f3 == 3'b001 && f7 == 7'h00) ||
                    (f3 == 3'b101 && {f7[6], f7[4:0]} == 6'd0);
            if (legal) begin
                alu = int_op(f3, (f3 == 3'b101) && f7[5]);
                ope = OPE_RS1_IMM;
            end
        end
        OPC_OP_32: begin
            legal = (f3 == 3'b001 && f7 == 7'h00) ||
                    ((f3 == 3'b000 || f3 == 3'b101) && {f7[6], f7[4:0]} == 6'd0);
            if (legal) begin
                fmt = R_TYPE;
                alu = int_op(f3, f7[5]);
                ope = OPE_RS1_RS2;
            end
        end
        default: begin
        end
    endcase
endfunction

// Immediate bit assembly per format, sign-extended to 64 bits
function automatic logic [63:0] predict_imm(input logic [31:0] w, input inst_type_e fmt);
    case (fmt)
        I_TYPE:  return {{52{w[31]}}, w[31:20]};
        S_TYPE:  return {{52{w[31]}}, w[31:25], w[11:7]};
        B_TYPE:  return {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        U_TYPE:  return {{32{w[31]}}, w[31:12], 12'd0};
        J_TYPE:  return {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        default: return 64'd0;
    endcase
endfunction

//////////////////////////////
// Encoder for the kept set, r and s give the free fields
//////////////////////////////
function automatic logic [31:0] encode_inst(input int pick, input logic [31:0] r,
                                            input logic [31:0] s);
    rv_inst_u   inst;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    inst = r;
    f3   = r[14:12];
    f7   = r[31:25];
    case (pick)
        0: opc = OPC_LUI;
        1: opc = OPC_AUIPC;
        2: opc = OPC_JAL;
        3: begin
            opc = OPC_JALR;
            f3  = F3_JALR;
        end
        4: begin
            opc = OPC_BRANCH;
            f3  = s[2] ? {1'b1, s[1:0]} : {2'b00, s[0]};
        end
        5: begin
            opc = OPC_LOAD;
            f3  = (s[2:0] == 3'b111) ? 3'b000 : s[2:0];
        end
        6: begin
            opc = OPC_STORE;
            f3  = {1'b0, s[1:0]};
        end
        7: begin
            opc = OPC_OP_IMM;
            f3  = s[2:0];
            if (f3 == F3_SLL) begin
                f7 = {6'd0, r[25]};
            end else if (f3 == F3_SRL) begin
                f7 = {1'b0, s[3], 4'd0, r[25]};
            end
        end
        8: begin
            opc = OPC_OP;
            f3  = s[2:0];
            f7  = (s[3] && (f3 == F3_ADD || f3 == F3_SRL)) ? F7_ALT : F7_BASE;
        end
        default: begin
            // W forms, immediate or register
            opc = (pick == 9) ? OPC_OP_IMM_32 : OPC_OP_32;
            f3  = s[1] ? F3_SRL : (s[0] ? F3_SLL : F3_ADD);
            if (f3 == F3_SLL) begin
                f7 = F7_BASE;
            end else if (f3 == F3_SRL || opc == OPC_OP_32) begin
                f7 = {1'b0, s[3], 5'd0};
            end
        end
    endcase
    inst.r.opcode = opc;
    inst.r.funct3 = f3;
    inst.r.funct7 = f7;
    return inst;
endfunction

`endif

/* tb_rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decoder
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
();

    localparam int NUM_INST    = 2000;
    localparam int CYCLE_LIMIT = 2 * NUM_INST + 50;

    logic        clk;
    logic        arst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        dec_valid;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rs3;
    logic [4:0]  rd;
    logic [63:0] imm;
    opcode_e     opcode;
    alu_e        alu_type;
    ope_sel_e    ope_sel;
    data_size_e  data_size;

    int          seed    = 32'hd574;
    int          errors  = 0;
    int          strobes = 0;
    int          valids  = 0;
    int          cycles  = 0;
    logic        strobe_d = 1'b0;
    logic [31:0] exp_q[$];

    `include "tb_rv_decoder_model.svh"

    rv_decoder_top #(
        .XLEN (64)
    ) rv_decoder_top_inst (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .dec_valid_o  (dec_valid),
        .rs1_addr_o   (rs1),
        .rs2_addr_o   (rs2),
        .rs3_addr_o   (rs3),
        .rd_addr_o    (rd),
        .imm_o        (imm),
        .opcode_o     (opcode),
        .alu_type_o   (alu_type),
        .ope_sel_o    (ope_sel),
        .data_size_o  (data_size)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("Summary: %0d errors, %0d strobes, %0d valid outputs",
                     errors, strobes, valids);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %0t ns %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    //////////////////////////////
    // Output check, once per falling edge
    //////////////////////////////
    task automatic check_output();
        logic [31:0] w;
        opcode_e     cls;
        inst_type_e  fmt;
        alu_e        alu;
        ope_sel_e    ope;
        data_size_e  size;
        compare_field("dec_valid_o", dec_valid, strobe_d);
        if (dec_valid === 1'b1) begin
            valids++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Valid output at %0t ns with no instruction waiting", $time);
            end else begin
                w   = exp_q.pop_front();
                cls = opcode_class(w[6:0]);
                predict_ctrl(w, fmt, alu, ope, size);
                compare_field("opcode_o", opcode, cls);
                compare_field("alu_type_o", alu_type, alu);
                compare_field("ope_sel_o", ope_sel, ope);
                compare_field("data_size_o", data_size, size);
                compare_field("imm_o", imm, predict_imm(w, fmt));
                compare_field("rs1_addr_o", rs1, w[19:15]);
                compare_field("rs2_addr_o", rs2, w[24:20]);
                compare_field("rs3_addr_o", rs3, w[31:27]);
                // No destination for stores and branches
                if (cls inside {STORE, STORE_FP, BRANCH}) begin
                    compare_field("rd_addr_o", rd, 5'd0);
                end else begin
                    compare_field("rd_addr_o", rd, w[11:7]);
                end
            end
        end
    endtask

    initial begin
        int          gap;
        int          pick;
        logic [31:0] r;
        logic [31:0] s;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = 32'd0;
        gap        = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        compare_field("dec_valid_o", dec_valid, 1'b0);
        compare_field("rs1_addr_o", rs1, 5'd0);
        compare_field("rs2_addr_o", rs2, 5'd0);
        compare_field("rs3_addr_o", rs3, 5'd0);
        compare_field("rd_addr_o", rd, 5'd0);
        compare_field("imm_o", imm, 64'd0);
        compare_field("opcode_o", opcode, 64'd0);
        compare_field("alu_type_o", alu_type, 64'd0);
        compare_field("ope_sel_o", ope_sel, 64'd0);
        compare_field("data_size_o", data_size, 64'd0);
        arst_n = 1'b1;

        //////////////////////////////
        // Random instructions with 0 or 1 idle cycles
        //////////////////////////////
        while (strobes < NUM_INST) begin
            @(negedge clk);
            check_output();
            if (gap > 0) begin
                inst_valid = 1'b0;
                gap--;
            end else begin
                r    = $random(seed);
                s    = $random(seed);
                pick = {$random(seed)} % 11;
                // About one word in eight is raw
                if ((s[7:5]) == 3'd0) begin
                    inst = r;
                end else begin
                    inst = encode_inst(pick, r, s);
                end
                inst_valid = 1'b1;
                exp_q.push_back(inst);
                strobes++;
                gap = $random(seed) & 1;
            end
            strobe_d = inst_valid;
        end

        // Drain the last output, then confirm nothing more arrives
        @(negedge clk);
        check_output();
        inst_valid = 1'b0;
        strobe_d   = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_output();
        end

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d instructions never gave a valid output", exp_q.size());
        end
        if (valids != strobes) begin
            errors++;
            $display("Valid output count %0d differs from strobe count %0d", valids, strobes);
        end
        $display("Summary: %0d errors, %0d strobes, %0d valid outputs",
                 errors, strobes, valids);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
